// File: Bender.yml
package:
  name: cheat_engine

sources:
  # package first, then leaf modules, then the top level
  - src/cheat_pkg.sv
  - src/cheat_code_regs.sv
  - src/cpu_read_timer.sv
  - src/cheat_slot_match.sv
  - src/cheat_data_mux.sv
  - src/cheat_engine_top.sv

  - target: test
    files:
      - tests/tb_cheat_engine.sv

// File: files.f
src/cheat_pkg.sv
src/cheat_code_regs.sv
src/cpu_read_timer.sv
src/cheat_slot_match.sv
src/cheat_data_mux.sv
src/cheat_engine_top.sv
tests/tb_cheat_engine.sv

// File: src/cheat_code_regs.sv
`timescale 1ns/1ns

module cheat_code_regs #(
	parameter int NUM_SLOTS = 8
) (
	input  logic                                   clk,
	input  logic                                   reset,
	input  cheat_pkg::host_wr_t                    host,
	output cheat_pkg::cheat_code_t [NUM_SLOTS-1:0] codes
);

	import cheat_pkg::*;

	slot_idx_t  wr_slot;
	logic [1:0] wr_byte;
	logic       slot_ok;
	logic       wr_en;

	// ------------------------------------------------------------------------
	// host address decode
	// ------------------------------------------------------------------------

	assign wr_slot = host.addr[7:2];
	assign wr_byte = host.addr[1:0];
	assign slot_ok = int'(wr_slot) < NUM_SLOTS;  // upper slots not built
	assign wr_en   = host.sel & host.we & slot_ok;

	// ------------------------------------------------------------------------
	// code storage, one byte per write
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (reset)
			codes <= '0;  // all slots off
		else if (wr_en)
		begin
			case (wr_byte)
				2'd0: codes[wr_slot].addr_lo <= host.data;
				2'd1: codes[wr_slot].addr_hi <= host.data;
				2'd2: codes[wr_slot].cmp     <= host.data;
				2'd3: codes[wr_slot].rep     <= host.data;
				default: ;
			endcase
		end
	end

endmodule

// File: src/cheat_data_mux.sv
`timescale 1ns/1ns

module cheat_data_mux #(
	parameter int NUM_SLOTS = 8
) (
	input  cheat_pkg::cheat_code_t [NUM_SLOTS-1:0] codes,
	input  logic [NUM_SLOTS-1:0]                   hits,
	input  logic                                   read_ok,
	input  logic                                   cheat_on,
	input  logic                                   dma_busy,
	input  logic                                   menu_active,
	output cheat_pkg::byte_t                       cheat_data,
	output logic                                   cheat_oe
);

	import cheat_pkg::*;

	slot_idx_t win_idx;
	logic      any_hit;
	logic      window;
	logic      gate_ok;
	byte_t     win_rep;

	// ------------------------------------------------------------------------
	// priority pick
	// ------------------------------------------------------------------------

	// walk down so the lowest set bit is written last
	always_comb
	begin
		win_idx = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--)
		begin
			if (hits[i])
				win_idx = slot_idx_t'(i);
		end
	end

	assign any_hit = |hits;
	assign win_rep = codes[win_idx].rep;

	// ------------------------------------------------------------------------
	// output
	// ------------------------------------------------------------------------

	assign window  = any_hit & read_ok;
	assign gate_ok = cheat_on & ~dma_busy & ~menu_active;  // dma and menu own the bus

	assign cheat_data = window ? win_rep : '0;
	assign cheat_oe   = window & gate_ok;

endmodule

// File: src/cheat_engine_top.sv
`timescale 1ns/1ns

module cheat_engine_top #(
	parameter int NUM_SLOTS  = 8,
	parameter int READ_DELAY = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  cheat_pkg::cpu_bus_t cpu,
	input  cheat_pkg::host_wr_t host,
	input  logic                cheat_on,
	input  logic                dma_busy,
	input  logic                menu_active,
	output cheat_pkg::byte_t    cheat_data,
	output logic                cheat_oe
);

	import cheat_pkg::*;

	cheat_code_t [NUM_SLOTS-1:0] codes;
	logic [NUM_SLOTS-1:0]        hits;
	logic                        read_ok;

	// slot index is 6 bits, counter is 4 bits
	if (NUM_SLOTS < 1 || NUM_SLOTS > 64)
	begin : g_bad_slots
		$error("NUM_SLOTS must be 1 to 64");
	end
	if (READ_DELAY < 1 || READ_DELAY > 15)
	begin : g_bad_delay
		$error("READ_DELAY must be 1 to 15");
	end

	// ------------------------------------------------------------------------
	// decode, code register file
	// ------------------------------------------------------------------------

	cheat_code_regs #(
		.NUM_SLOTS (NUM_SLOTS)
	) i_cheat_code_regs (
		.clk   (clk),
		.reset (reset),
		.host  (host),
		.codes (codes)
	);

	// ------------------------------------------------------------------------
	// execute, read timing and per slot compare
	// ------------------------------------------------------------------------

	cpu_read_timer #(
		.READ_DELAY (READ_DELAY)
	) i_cpu_read_timer (
		.clk     (clk),
		.reset   (reset),
		.cpu     (cpu),
		.read_ok (read_ok)
	);

	for (genvar s = 0; s < NUM_SLOTS; s++)
	begin : g_slot
		cheat_slot_match i_cheat_slot_match (
			.cpu  (cpu),
			.code (codes[s]),
			.hit  (hits[s])
		);
	end

	// ------------------------------------------------------------------------
	// result, priority mux and gating
	// ------------------------------------------------------------------------

	cheat_data_mux #(
		.NUM_SLOTS (NUM_SLOTS)
	) i_cheat_data_mux (
		.codes       (codes),
		.hits        (hits),
		.read_ok     (read_ok),
		.cheat_on    (cheat_on),
		.dma_busy    (dma_busy),
		.menu_active (menu_active),
		.cheat_data  (cheat_data),
		.cheat_oe    (cheat_oe)
	);

	// override only ever answers a read that has been up long enough
	a_oe_in_read: assert property (
		@(posedge clk) disable iff (reset)
		cheat_oe |-> (cpu.m2 && cpu.rw && $past(cpu.m2 && cpu.rw, READ_DELAY + 1))
	) else $error("cheat_oe outside a settled cpu read");

endmodule

// File: src/cheat_pkg.sv
package cheat_pkg;

	// ------------------------------------------------------------------------
	// plain vectors
	// ------------------------------------------------------------------------

	typedef logic [7:0]  byte_t;       // code bytes, cpu and rom data
	typedef logic [14:0] cpu_addr_t;   // offset inside the 32 KB program area
	typedef logic [5:0]  slot_idx_t;   // host addr bits 7:2
	typedef logic [7:0]  host_addr_t;  // config register address

	// ------------------------------------------------------------------------
	// bus and code records
	// ------------------------------------------------------------------------

	// console side, sampled as is
	typedef struct packed {
		logic      m2;        // phase 2 strobe
		logic      rw;        // 1 = read
		cpu_addr_t addr;
		byte_t     prg_data;  // what the rom is returning right now
	} cpu_bus_t;

	// config processor write port
	typedef struct packed {
		logic       sel;   // cheat block selected
		logic       we;    // single cycle strobe
		host_addr_t addr;
		byte_t      data;
	} host_wr_t;

	// one stored code, host byte order is lo, hi, cmp, rep
	typedef struct packed {
		byte_t addr_hi;  // bit 7 enables the slot
		byte_t addr_lo;
		byte_t cmp;
		byte_t rep;      // cmp == rep means address only
	} cheat_code_t;

endpackage

// File: src/cheat_slot_match.sv
`timescale 1ns/1ns

module cheat_slot_match (
	input  cheat_pkg::cpu_bus_t    cpu,
	input  cheat_pkg::cheat_code_t code,
	output logic                   hit
);

	import cheat_pkg::*;

	logic      slot_en;
	cpu_addr_t code_addr;
	logic      addr_eq;
	logic      data_eq;
	logic      cmp_off;

	// ------------------------------------------------------------------------
	// address side
	// ------------------------------------------------------------------------

	assign slot_en   = code.addr_hi[7];
	assign code_addr = {code.addr_hi[6:0], code.addr_lo};
	assign addr_eq   = slot_en & (code_addr == cpu.addr);

	// ------------------------------------------------------------------------
	// data side
	// ------------------------------------------------------------------------

	assign data_eq = cpu.prg_data == code.cmp;
	assign cmp_off = code.cmp == code.rep;  // address only code

	assign hit = addr_eq & (data_eq | cmp_off);

endmodule

// File: src/cpu_read_timer.sv
`timescale 1ns/1ns

module cpu_read_timer #(
	parameter int READ_DELAY = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  cheat_pkg::cpu_bus_t cpu,
	output logic                read_ok
);

	logic       read_live;  // m2 and rw high right now
	logic [1:0] rd_st;      // registered read condition
	logic [3:0] rd_cnt;

	assign read_live = cpu.m2 & cpu.rw;

	// ------------------------------------------------------------------------
	// stable read counter
	// ------------------------------------------------------------------------

	// rd_st[1] adds the latch delay, so the window opens
	// READ_DELAY+1 edges after the first edge that saw the read
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_st  <= '0;
			rd_cnt <= '0;
		end
		else
		begin
			rd_st <= {rd_st[0], read_live};
			if (!rd_st[1] || !read_live)
				rd_cnt <= '0;
			else if (rd_cnt != 4'(READ_DELAY))
				rd_cnt <= rd_cnt + 4'd1;  // saturate at READ_DELAY
		end
	end

	// drops at once when the strobes go away
	assign read_ok = (rd_cnt == 4'(READ_DELAY)) & read_live;

	a_cnt_max: assert property (
		@(posedge clk) disable iff (reset)
		rd_cnt <= 4'(READ_DELAY)
	) else $error("read counter ran past READ_DELAY");

endmodule

// File: tests/tb_cheat_engine.sv
`timescale 1ns/1ns

module tb_cheat_engine;

	import cheat_pkg::*;

	localparam int NUM_SLOTS  = 8;
	localparam int READ_DELAY = 4;
	localparam int OE_TIMEOUT = 40;  // cycles

	typedef struct packed {
		logic  oe;
		byte_t data;
	} override_t;

	logic     clk;
	logic     reset;
	cpu_bus_t cpu;
	host_wr_t host;
	logic     cheat_on;
	logic     dma_busy;
	logic     menu_active;
	byte_t    cheat_data;
	logic     cheat_oe;

	cheat_code_t [NUM_SLOTS-1:0] shadow;  // what the dut should hold

	// sample request to the compare process
	logic      chk_on;
	override_t chk_exp;
	string     chk_point;

	integer seed;
	int     n_checks;
	int     n_errors;
	int     test_checks;
	int     test_errors;

	always #10 clk = ~clk;

	cheat_engine_top #(
		.NUM_SLOTS  (NUM_SLOTS),
		.READ_DELAY (READ_DELAY)
	) i_cheat_engine_top (
		.clk         (clk),
		.reset       (reset),
		.cpu         (cpu),
		.host        (host),
		.cheat_on    (cheat_on),
		.dma_busy    (dma_busy),
		.menu_active (menu_active),
		.cheat_data  (cheat_data),
		.cheat_oe    (cheat_oe)
	);

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	function automatic override_t expected_override(
		input cheat_code_t [NUM_SLOTS-1:0] codes,
		input cpu_addr_t                   addr,
		input byte_t                       data,
		input logic                        on,
		input logic                        dma,
		input logic                        menu
	);
		override_t r;
		logic      found;
		r     = '0;
		found = 1'b0;
		for (int s = 0; s < NUM_SLOTS; s++)
		begin
			// lowest enabled slot with address and data agreeing wins
			if (!found && codes[s].addr_hi[7]
				&& {codes[s].addr_hi[6:0], codes[s].addr_lo} == addr
				&& (codes[s].cmp == codes[s].rep || codes[s].cmp == data))
			begin
				found  = 1'b1;
				r.data = codes[s].rep;
			end
		end
		r.oe = found && on && !dma && !menu;
		return r;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	// ------------------------------------------------------------------------
	// compare process, samples mid cycle
	// ------------------------------------------------------------------------

	always @(negedge clk)
	begin
		if (chk_on)
		begin
			n_checks = n_checks + 2;
			a_oe: assert (cheat_oe === chk_exp.oe)
			else
			begin
				$display("Fail at %0t ns: cheat_oe expected %b, got %b (%s)",
					$time, chk_exp.oe, cheat_oe, chk_point);
				n_errors++;
			end
			a_data: assert (cheat_data === chk_exp.data)
			else
			begin
				$display("Fail at %0t ns: cheat_data expected %h, got %h (%s)",
					$time, chk_exp.data, cheat_data, chk_point);
				n_errors++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------------------

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic request_check(input override_t e, input string point);
		chk_exp   = e;
		chk_point = point;
		chk_on    = 1'b1;
	endtask

	task automatic host_write(input host_addr_t addr, input byte_t data);
		slot_idx_t slot;
		slot      = addr[7:2];
		host.sel  = 1'b1;
		host.we   = 1'b1;
		host.addr = addr;
		host.data = data;
		if (int'(slot) < NUM_SLOTS)
		begin
			case (addr[1:0])
				2'd0: shadow[slot].addr_lo = data;
				2'd1: shadow[slot].addr_hi = data;
				2'd2: shadow[slot].cmp     = data;
				2'd3: shadow[slot].rep     = data;
				default: ;
			endcase
		end
		next_cycle();
		host.sel = 1'b0;
		host.we  = 1'b0;
	endtask

	task automatic program_slot(
		input int        slot,
		input cpu_addr_t addr,
		input byte_t     cmp,
		input byte_t     rep,
		input logic      en
	);
		host_addr_t base;
		base = host_addr_t'(slot << 2);
		host_write(base | 8'd0, addr[7:0]);
		host_write(base | 8'd1, {en, addr[14:8]});
		host_write(base | 8'd2, cmp);
		host_write(base | 8'd3, rep);
	endtask

	// hold is the number of edges that see the strobes, at least READ_DELAY+3
	task automatic cpu_read(
		input cpu_addr_t addr,
		input byte_t     data,
		input logic      rw,
		input int        hold
	);
		override_t hit_exp;
		int        k;
		hit_exp = expected_override(shadow, addr, data, cheat_on, dma_busy, menu_active);
		if (!rw)
			hit_exp = '0;  // a write never opens the window
		cpu.m2       = 1'b1;
		cpu.rw       = rw;
		cpu.addr     = addr;
		cpu.prg_data = data;
		// cycle k lies between edge k and edge k+1
		for (k = -1; k < hold - 1; k++)
		begin
			if (k == READ_DELAY)
				request_check('0, "before window");
			else if (k == READ_DELAY + 1)
				request_check(hit_exp, "window open");
			else if (k == hold - 2)
				request_check(hit_exp, "read end");
			else
				chk_on = 1'b0;
			next_cycle();
		end
		cpu.m2 = 1'b0;
		cpu.rw = 1'b0;
		request_check('0, "after drop");
		next_cycle();
		chk_on = 1'b0;
		repeat (2)
			next_cycle();  // let the read flag drain
	endtask

	task automatic wait_oe_rise(output int cycles, output logic seen);
		int n;
		seen   = 1'b0;
		cycles = 0;
		for (n = 0; n < OE_TIMEOUT && !seen; n++)
		begin
			@(negedge clk);
			if (cheat_oe)
			begin
				seen   = 1'b1;
				cycles = n;
			end
		end
	endtask

	task automatic load_random_codes();
		cpu_addr_t addr;
		byte_t     cmp;
		byte_t     rep;
		logic      en;
		int        src;
		for (int s = 0; s < NUM_SLOTS; s++)
		begin
			addr = cpu_addr_t'($random(seed));
			if (s > 0 && rand_below(4) == 0)
			begin
				src  = rand_below(s);  // share an address with a lower slot
				addr = {shadow[src].addr_hi[6:0], shadow[src].addr_lo};
			end
			cmp = byte_t'($random(seed));
			rep = (rand_below(3) == 0) ? cmp : byte_t'($random(seed));
			en  = rand_below(8) != 0;
			program_slot(s, addr, cmp, rep, en);
		end
	endtask

	task automatic random_read();
		int        t;
		cpu_addr_t addr;
		byte_t     data;
		logic      rw;
		t = rand_below(NUM_SLOTS);
		if (rand_below(4) != 0)
		begin
			addr = {shadow[t].addr_hi[6:0], shadow[t].addr_lo};
			data = rand_below(2) ? shadow[t].cmp : byte_t'($random(seed));
		end
		else
		begin
			addr = cpu_addr_t'($random(seed));
			data = byte_t'($random(seed));
		end
		cheat_on    = rand_below(8) != 0;
		dma_busy    = rand_below(8) == 0;
		menu_active = rand_below(8) == 0;
		rw          = rand_below(10) != 0;
		cpu_read(addr, data, rw, READ_DELAY + 3 + rand_below(5));
	endtask

	task automatic start_test();
		test_checks = n_checks;
		test_errors = n_errors;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name,
			n_checks - test_checks, n_errors - test_errors);
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial
	begin
		int   rise_at;
		logic seen;
		seed        = 32'hff;
		clk         = 1'b0;
		reset       = 1'b1;
		cpu         = '0;
		host        = '0;
		cheat_on    = 1'b1;
		dma_busy    = 1'b0;
		menu_active = 1'b0;
		shadow      = '0;
		chk_on      = 1'b0;
		chk_exp     = '0;
		chk_point   = "";
		n_checks    = 0;
		n_errors    = 0;
		repeat (10)
			@(posedge clk);
		#2;
		reset = 1'b0;
		next_cycle();

		start_test();
		cpu_read(15'h0000, 8'h00, 1'b1, READ_DELAY + 4);
		cpu_read(15'h7fff, 8'hff, 1'b1, READ_DELAY + 4);
		cpu_read(15'h2a55, 8'h3c, 1'b1, READ_DELAY + 5);
		end_test("reset idle");

		start_test();
		program_slot(0, 15'h0123, 8'h47, 8'h47, 1'b1);
		fork
			cpu_read(15'h0123, 8'hea, 1'b1, READ_DELAY + 6);
			wait_oe_rise(rise_at, seen);
		join
		if (!seen)
		begin
			$display("timeout: cheat_oe did not rise within %0d cycles", OE_TIMEOUT);
			n_errors++;
		end
		else
		begin
			n_checks++;
			a_rise: assert (rise_at == READ_DELAY + 2)
			else
			begin
				$display("Fail at %0t ns: cheat_oe rise cycle expected %0d, got %0d",
					$time, READ_DELAY + 2, rise_at);
				n_errors++;
			end
		end
		end_test("address only");

		start_test();
		program_slot(2, 15'h1234, 8'h5a, 8'ha5, 1'b1);
		cpu_read(15'h1234, 8'h5a, 1'b1, READ_DELAY + 5);
		cpu_read(15'h1234, 8'h11, 1'b1, READ_DELAY + 5);
		end_test("compare mode");

		start_test();
		program_slot(1, 15'h3456, 8'h10, 8'h10, 1'b1);
		program_slot(3, 15'h3456, 8'h20, 8'h20, 1'b1);
		cpu_read(15'h3456, 8'h00, 1'b1, READ_DELAY + 5);
		host_write(8'h05, {1'b0, 7'h34});  // slot 1 off
		cpu_read(15'h3456, 8'h00, 1'b1, READ_DELAY + 5);
		end_test("priority");

		start_test();
		program_slot(0, 15'h0400, 8'h3c, 8'h3c, 1'b1);
		cheat_on = 1'b0;
		cpu_read(15'h0400, 8'h00, 1'b1, READ_DELAY + 4);
		cheat_on = 1'b1;
		dma_busy = 1'b1;
		cpu_read(15'h0400, 8'h00, 1'b1, READ_DELAY + 4);
		dma_busy    = 1'b0;
		menu_active = 1'b1;
		cpu_read(15'h0400, 8'h00, 1'b1, READ_DELAY + 4);
		menu_active = 1'b0;
		cpu_read(15'h0400, 8'h00, 1'b0, READ_DELAY + 4);
		program_slot(NUM_SLOTS, 15'h0400, 8'h99, 8'h99, 1'b1);
		cpu_read(15'h0400, 8'h00, 1'b1, READ_DELAY + 4);
		end_test("blocking");

		start_test();
		for (int i = 0; i < 200; i++)
		begin
			if (i % 50 == 0)
				load_random_codes();
			random_read();
		end
		cheat_on    = 1'b1;
		dma_busy    = 1'b0;
		menu_active = 1'b0;
		end_test("random");

		$display("total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
